/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_commit_top
RTL_TOP   ?= hsv_commit_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
source/hsv_isa_pkg.sv
source/hsv_core_pkg.sv
source/hsv_alu_unit.sv
source/hsv_branch_unit.sv
source/hsv_core_commit.sv
source/hsv_commit_top.sv
sim/tb_clock_gen.sv
sim/tb_commit_top.sv

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* sim/tb_commit_top.sv */
`timescale 1ns/1ps

module tb_commit_top
  import hsv_isa_pkg::*;
  import hsv_core_pkg::*;
();

  localparam int NUM_ROWS       = 25;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 20;

  localparam logic [1:0] MODE_SINGLE = 2'd0;
  localparam logic [1:0] MODE_PAIR   = 2'd1;
  localparam logic [1:0] MODE_IRQ    = 2'd2;

  typedef struct packed {
    word        insn;
    word        pc;
    word        rs1;
    word        rs2;
    insn_token  tok;
    logic [1:0] mode;
    logic       wen;
    reg_addr    waddr;
    word        wdata;
    word        npc;
    logic       jump;
    logic       trap;
    logic [4:0] cause;
    word        tval;
  } row_t;

  logic       clk_core;
  logic       rst_core_n;
  logic       issue_valid_i;
  word        insn_i;
  word        pc_i;
  word        rs1_val_i;
  word        rs2_val_i;
  insn_token  token_i;
  logic       flush_req_i;
  logic       begin_irq_i;
  logic       flush_ack_o;
  logic       commit_o;
  logic       flush_begin_o;
  logic       trap_o;
  logic [4:0] trap_cause_o;
  word        trap_value_o;
  word        next_pc_o;
  reg_addr    wr_addr_o;
  word        wr_data_o;
  logic       wr_en_o;
  reg_mask    commit_mask_o;

  row_t rows [NUM_ROWS];
  int   nrows;
  int   errors;
  int   checks;
  int   cycles = 0;
  word  last_npc;

  tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk_o(clk_core));

  hsv_commit_top dut (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .issue_valid_i (issue_valid_i),
    .insn_i        (insn_i),
    .pc_i          (pc_i),
    .rs1_val_i     (rs1_val_i),
    .rs2_val_i     (rs2_val_i),
    .token_i       (token_i),
    .flush_req_i   (flush_req_i),
    .begin_irq_i   (begin_irq_i),
    .flush_ack_o   (flush_ack_o),
    .commit_o      (commit_o),
    .flush_begin_o (flush_begin_o),
    .trap_o        (trap_o),
    .trap_cause_o  (trap_cause_o),
    .trap_value_o  (trap_value_o),
    .next_pc_o     (next_pc_o),
    .wr_addr_o     (wr_addr_o),
    .wr_data_o     (wr_data_o),
    .wr_en_o       (wr_en_o),
    .commit_mask_o (commit_mask_o)
  );

  always @(posedge clk_core) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT did not retire all rows within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic compare(input string what, input word got, input word exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Independent model of the R-type operations
  function automatic word alu_ref(input logic [2:0] f3, input logic alt, input word a,
                                  input word b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return {31'd0, $signed(a) < $signed(b)};
      F3_XOR:     return a ^ b;
      F3_SRL:     return a >> b[4:0];
      F3_OR:      return a | b;
      F3_AND:     return a & b;
      default:    return '0;
    endcase
  endfunction

  task automatic alu_row(input logic [6:0] f7, input logic [2:0] f3, input reg_addr rd,
                         input word a, input word b, input insn_token tok, input word exp,
                         input logic [1:0] mode);
    row_t r;
    r       = '0;
    r.insn  = {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
    r.pc    = 32'h0000_1000 + nrows * 16;
    r.rs1   = a;
    r.rs2   = b;
    r.tok   = tok;
    r.mode  = mode;
    r.wen   = rd != 5'd0;
    r.waddr = rd;
    r.wdata = exp;
    r.npc   = r.pc + 32'd4;
    rows[nrows] = r;
    nrows++;
  endtask

  task automatic br_row(input logic [2:0] f3, input logic [12:0] off, input word a,
                        input word b, input insn_token tok, input logic taken,
                        input logic [1:0] mode);
    row_t r;
    r      = '0;
    r.insn = {off[12], off[10:5], 5'd4, 5'd3, f3, off[4:1], off[11], OPC_BRANCH};
    r.pc   = 32'h0000_1000 + nrows * 16;
    r.rs1  = a;
    r.rs2  = b;
    r.tok  = tok;
    r.mode = mode;
    r.jump = taken;
    r.npc  = taken ? r.pc + {{19{off[12]}}, off} : r.pc + 32'd4;
    rows[nrows] = r;
    nrows++;
  endtask

  task automatic mark_trap(input logic [4:0] cause, input word tval);
    rows[nrows-1].trap  = 1'b1;
    rows[nrows-1].wen   = 1'b0;
    rows[nrows-1].cause = cause;
    rows[nrows-1].tval  = tval;
  endtask

  task automatic build_table();
    logic [2:0] codes [7];
    logic [2:0] f3;
    logic       alt;
    word        a;
    word        b;
    codes = '{F3_ADD_SUB, F3_SLL, F3_SLT, F3_XOR, F3_SRL, F3_OR, F3_AND};
    nrows = 0;
    alu_row(F7_BASE, F3_ADD_SUB, 5'd5, 32'd7, 32'd9, 3'd0, 32'd16, MODE_SINGLE);
    alu_row(F7_ALT, F3_ADD_SUB, 5'd6, 32'd5, 32'd12, 3'd1, 32'hFFFF_FFF9, MODE_SINGLE);
    alu_row(F7_BASE, F3_SLL, 5'd7, 32'd3, 32'h24, 3'd2, 32'h30, MODE_SINGLE);
    alu_row(F7_BASE, F3_SLT, 5'd8, 32'hFFFF_FFFE, 32'd1, 3'd3, 32'd1, MODE_SINGLE);
    alu_row(F7_BASE, F3_XOR, 5'd9, 32'hF0F0_F0F0, 32'hFF00_FF00, 3'd4, 32'h0FF0_0FF0,
            MODE_SINGLE);
    alu_row(F7_BASE, F3_SRL, 5'd10, 32'h8000_0000, 32'd31, 3'd5, 32'd1, MODE_SINGLE);
    alu_row(F7_BASE, F3_OR, 5'd11, 32'h00FF_0000, 32'h0000_FF00, 3'd6, 32'h00FF_FF00,
            MODE_SINGLE);
    alu_row(F7_BASE, F3_AND, 5'd31, 32'h1234_5678, 32'h0F0F_0F0F, 3'd7, 32'h0204_0608,
            MODE_SINGLE);
    // x0 destination, no writeback
    alu_row(F7_BASE, F3_ADD_SUB, 5'd0, 32'd1, 32'd2, 3'd0, 32'd3, MODE_SINGLE);
    for (int k = 0; k < 4; k++) begin
      a   = $urandom();
      b   = $urandom();
      f3  = codes[$urandom_range(6, 0)];
      alt = (f3 == F3_ADD_SUB) && ($urandom() % 2 == 1);
      alu_row(alt ? F7_ALT : F7_BASE, f3, reg_addr'($urandom_range(31, 1)), a, b,
              insn_token'(k + 1), alu_ref(f3, alt, a, b), MODE_SINGLE);
    end
    br_row(F3_BEQ, 13'd16, 32'd5, 32'd5, 3'd5, 1'b1, MODE_SINGLE);
    br_row(F3_BNE, 13'd8, 32'd5, 32'd5, 3'd6, 1'b0, MODE_SINGLE);
    br_row(F3_BLT, -13'sd32, 32'hFFFF_FFFD, 32'd2, 3'd7, 1'b1, MODE_SINGLE);
    br_row(F3_BGE, 13'd12, 32'd1, 32'd2, 3'd0, 1'b0, MODE_SINGLE);
    alu_row(7'h01, F3_ADD_SUB, 5'd3, 32'd1, 32'd1, 3'd1, 32'd0, MODE_SINGLE);
    mark_trap(5'd2, rows[nrows-1].insn);
    // Younger ALU op issued ahead of the older branch
    alu_row(F7_BASE, F3_ADD_SUB, 5'd12, 32'd100, 32'd23, 3'd1, 32'd123, MODE_PAIR);
    br_row(F3_BNE, 13'd8, 32'd1, 32'd2, 3'd0, 1'b1, MODE_SINGLE);
    br_row(F3_BEQ, 13'd6, 32'd0, 32'd0, 3'd2, 1'b1, MODE_SINGLE);
    mark_trap(5'd0, rows[nrows-1].npc);
    alu_row(F7_BASE, F3_XOR, 5'd13, 32'hA5, 32'h5A, 3'd0, 32'hFF, MODE_IRQ);
    alu_row(F7_BASE, F3_AND, 5'd14, 32'hFF, 32'h0F, 3'd1, 32'h0F, MODE_PAIR);
    br_row(F3_BLT, 13'd8, 32'd1, 32'hFFFF_FFFF, 3'd0, 1'b0, MODE_SINGLE);
    alu_row(F7_ALT, F3_ADD_SUB, 5'd15, 32'd10, 32'd3, 3'd2, 32'd7, MODE_SINGLE);
  endtask

  task automatic issue_row(input int i);
    issue_valid_i = 1'b1;
    insn_i        = rows[i].insn;
    pc_i          = rows[i].pc;
    rs1_val_i     = rows[i].rs1;
    rs2_val_i     = rows[i].rs2;
    token_i       = rows[i].tok;
    @(negedge clk_core);
    issue_valid_i = 1'b0;
  endtask

  task automatic do_flush();
    flush_req_i = 1'b1;
    @(negedge clk_core);
    compare("flush_ack_o", flush_ack_o, 1);
    flush_req_i = 1'b0;
    @(negedge clk_core);
    compare("flush_ack_o low", flush_ack_o, 0);
  endtask

  task automatic check_row(input int i);
    row_t r;
    logic wr_seen;
    r       = rows[i];
    wr_seen = 1'b0;
    while (!(commit_o || trap_o)) begin
      wr_seen = wr_seen | wr_en_o;
      @(negedge clk_core);
    end
    compare("commit_o", commit_o, !r.trap);
    if (!r.trap) begin
      compare("wr_en_o", wr_en_o, r.wen);
      if (r.wen) begin
        compare("wr_addr_o", wr_addr_o, r.waddr);
        compare("wr_data_o", wr_data_o, r.wdata);
      end
      compare("commit_mask_o", commit_mask_o,
              r.insn[6:0] == OPC_OP ? 32'd1 << r.waddr : 32'd0);
      compare("flush_begin_o", flush_begin_o, r.jump);
      @(negedge clk_core);
      compare("next_pc_o", next_pc_o, r.npc);
      compare("trap_o", trap_o, 0);
      last_npc = r.npc;
    end else begin
      compare("trap_cause_o", trap_cause_o, r.cause);
      compare("trap_value_o", trap_value_o, r.tval);
      compare("next_pc_o after trap", next_pc_o, last_npc);
      compare("wr_en_o on trap", wr_seen, 0);
      do_flush();
    end
  endtask

  // First row carries the younger token and must wait
  task automatic run_pair(input int i);
    issue_row(i);
    compare("early commit_o", commit_o, 0);
    if (begin_irq_i) begin
      repeat (3) begin
        @(negedge clk_core);
        compare("commit_o under irq", commit_o, 0);
      end
      begin_irq_i = 1'b0;
    end
    issue_row(i + 1);
    check_row(i + 1);
    check_row(i);
  endtask

  initial begin
    int i;
    rst_core_n    = 1'b0;
    issue_valid_i = 1'b0;
    insn_i        = '0;
    pc_i          = '0;
    rs1_val_i     = '0;
    rs2_val_i     = '0;
    token_i       = '0;
    flush_req_i   = 1'b0;
    begin_irq_i   = 1'b0;
    errors        = 0;
    checks        = 0;
    last_npc      = '0;
    void'($urandom(19));
    build_table();
    repeat (5) @(negedge clk_core);
    rst_core_n = 1'b1;
    @(negedge clk_core);
    i = 0;
    while (i < NUM_ROWS) begin
      case (rows[i].mode)
        MODE_PAIR: begin
          run_pair(i);
          i += 2;
        end
        MODE_IRQ: begin
          begin_irq_i = 1'b1;
          issue_row(i);
          check_row(i);
          run_pair(i + 1);
          i += 3;
        end
        default: begin
          issue_row(i);
          check_row(i);
          i += 1;
        end
      endcase
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* source/hsv_alu_unit.sv */
`timescale 1ns/1ps

module hsv_alu_unit
  import hsv_isa_pkg::*;
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         issue_valid_i,
  input  insn_word_u   insn_i,
  input  word          pc_i,
  input  word          rs1_val_i,
  input  word          rs2_val_i,
  input  insn_token    token_i,
  input  logic         flush_i,
  input  logic         ready_i,
  output commit_data_t data_o,
  output logic         valid_o
);

  commit_data_t                    queue_q [UNIT_DEPTH];
  logic [$clog2(UNIT_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(UNIT_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(UNIT_DEPTH+1)-1:0] count_q;
  logic                            push;
  logic                            pop;
  logic                            illegal;
  word                             result;
  commit_data_t                    rec;

  assign push    = issue_valid_i & !flush_i & (insn_i.r_view.opcode == OPC_OP);
  assign valid_o = count_q != '0;
  assign pop     = valid_o & ready_i;
  assign data_o  = queue_q[rd_ptr_q];

  always_comb begin
    illegal = 1'b0;
    result  = '0;
    case (insn_i.r_view.funct3)
      F3_ADD_SUB: begin
        if (insn_i.r_view.funct7 == F7_BASE) result = rs1_val_i + rs2_val_i;
        else if (insn_i.r_view.funct7 == F7_ALT) result = rs1_val_i - rs2_val_i;
        else illegal = 1'b1;
      end
      F3_SLL: begin
        result  = rs1_val_i << rs2_val_i[4:0];
        illegal = insn_i.r_view.funct7 != F7_BASE;
      end
      F3_SLT: begin
        result  = {31'b0, $signed(rs1_val_i) < $signed(rs2_val_i)};
        illegal = insn_i.r_view.funct7 != F7_BASE;
      end
      F3_XOR: begin
        result  = rs1_val_i ^ rs2_val_i;
        illegal = insn_i.r_view.funct7 != F7_BASE;
      end
      F3_SRL: begin
        result  = rs1_val_i >> rs2_val_i[4:0];
        illegal = insn_i.r_view.funct7 != F7_BASE;
      end
      F3_OR: begin
        result  = rs1_val_i | rs2_val_i;
        illegal = insn_i.r_view.funct7 != F7_BASE;
      end
      F3_AND: begin
        result  = rs1_val_i & rs2_val_i;
        illegal = insn_i.r_view.funct7 != F7_BASE;
      end
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    rec            = '0;
    rec.token      = token_i;
    rec.rd_addr    = insn_i.r_view.rd;
    rec.result     = result;
    rec.writeback  = insn_i.r_view.rd != '0;
    rec.trap       = illegal;
    rec.trap_cause = CAUSE_ILLEGAL_INSN;
    rec.trap_value = insn_i;
    rec.next_pc    = pc_i + 32'd4;
    rec.rd_mask    = reg_mask'(1) << insn_i.r_view.rd;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      queue_q <= '{default: '0};
    end else if (push) begin
      queue_q[wr_ptr_q] <= rec;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push & !pop) count_q <= count_q + 1'b1;
      else if (pop & !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

/* source/hsv_branch_unit.sv */
`timescale 1ns/1ps

module hsv_branch_unit
  import hsv_isa_pkg::*;
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         issue_valid_i,
  input  insn_word_u   insn_i,
  input  word          pc_i,
  input  word          rs1_val_i,
  input  word          rs2_val_i,
  input  insn_token    token_i,
  input  logic         flush_i,
  input  logic         ready_i,
  output commit_data_t data_o,
  output logic         valid_o
);

  commit_data_t                    queue_q [UNIT_DEPTH];
  logic [$clog2(UNIT_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(UNIT_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(UNIT_DEPTH+1)-1:0] count_q;
  logic                            push;
  logic                            pop;
  logic                            taken;
  logic                            illegal;
  word                             offset;
  word                             target;
  commit_data_t                    rec;

  assign push    = issue_valid_i & !flush_i & (insn_i.b_view.opcode == OPC_BRANCH);
  assign valid_o = count_q != '0;
  assign pop     = valid_o & ready_i;
  assign data_o  = queue_q[rd_ptr_q];

  // Offset bits lie scattered over the word and bit 0 is always zero
  assign offset = {{19{insn_i.b_view.imm12}}, insn_i.b_view.imm12, insn_i.b_view.imm11,
                   insn_i.b_view.imm10_5, insn_i.b_view.imm4_1, 1'b0};
  assign target = pc_i + offset;

  always_comb begin
    illegal = 1'b0;
    case (insn_i.b_view.funct3)
      F3_BEQ: taken = rs1_val_i == rs2_val_i;
      F3_BNE: taken = rs1_val_i != rs2_val_i;
      F3_BLT: taken = $signed(rs1_val_i) < $signed(rs2_val_i);
      F3_BGE: taken = $signed(rs1_val_i) >= $signed(rs2_val_i);
      default: begin
        taken   = 1'b0;
        illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    rec         = '0;
    rec.token   = token_i;
    rec.jump    = taken;
    rec.next_pc = taken ? target : pc_i + 32'd4;
    if (illegal) begin
      rec.trap       = 1'b1;
      rec.trap_cause = CAUSE_ILLEGAL_INSN;
      rec.trap_value = insn_i;
    end else if (taken && target[1]) begin
      rec.trap       = 1'b1;
      rec.trap_cause = CAUSE_MISALIGNED_FETCH;
      rec.trap_value = target;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      queue_q <= '{default: '0};
    end else if (push) begin
      queue_q[wr_ptr_q] <= rec;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push & !pop) count_q <= count_q + 1'b1;
      else if (pop & !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

/* source/hsv_commit_top.sv */
`timescale 1ns/1ps

module hsv_commit_top
  import hsv_isa_pkg::*;
  import hsv_core_pkg::*;
(
  input  logic       clk_core,
  input  logic       rst_core_n,
  input  logic       issue_valid_i,
  input  insn_word_u insn_i,
  input  word        pc_i,
  input  word        rs1_val_i,
  input  word        rs2_val_i,
  input  insn_token  token_i,
  input  logic       flush_req_i,
  input  logic       begin_irq_i,
  output logic       flush_ack_o,
  output logic       commit_o,
  output logic       flush_begin_o,
  output logic       trap_o,
  output logic [4:0] trap_cause_o,
  output word        trap_value_o,
  output word        next_pc_o,
  output reg_addr    wr_addr_o,
  output word        wr_data_o,
  output logic       wr_en_o,
  output reg_mask    commit_mask_o
);

  commit_data_t alu_data;
  logic         alu_valid;
  logic         alu_ready;
  commit_data_t branch_data;
  logic         branch_valid;
  logic         branch_ready;

  hsv_alu_unit u_alu (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .issue_valid_i (issue_valid_i),
    .insn_i        (insn_i),
    .pc_i          (pc_i),
    .rs1_val_i     (rs1_val_i),
    .rs2_val_i     (rs2_val_i),
    .token_i       (token_i),
    .flush_i       (flush_req_i),
    .ready_i       (alu_ready),
    .data_o        (alu_data),
    .valid_o       (alu_valid)
  );

  hsv_branch_unit u_branch (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .issue_valid_i (issue_valid_i),
    .insn_i        (insn_i),
    .pc_i          (pc_i),
    .rs1_val_i     (rs1_val_i),
    .rs2_val_i     (rs2_val_i),
    .token_i       (token_i),
    .flush_i       (flush_req_i),
    .ready_i       (branch_ready),
    .data_o        (branch_data),
    .valid_o       (branch_valid)
  );

  // Per-lane commit pulses have no consumer at this level
  hsv_core_commit u_commit (
    .clk_core        (clk_core),
    .rst_core_n      (rst_core_n),
    .flush_req_i     (flush_req_i),
    .flush_ack_o     (flush_ack_o),
    .alu_data_i      (alu_data),
    .alu_valid_i     (alu_valid),
    .branch_data_i   (branch_data),
    .branch_valid_i  (branch_valid),
    .alu_ready_o     (alu_ready),
    .branch_ready_o  (branch_ready),
    .alu_commit_o    (),
    .branch_commit_o (),
    .commit_o        (commit_o),
    .begin_irq_i     (begin_irq_i),
    .flush_begin_o   (flush_begin_o),
    .trap_o          (trap_o),
    .trap_cause_o    (trap_cause_o),
    .trap_value_o    (trap_value_o),
    .next_pc_o       (next_pc_o),
    .wr_addr_o       (wr_addr_o),
    .wr_data_o       (wr_data_o),
    .wr_en_o         (wr_en_o),
    .commit_mask_o   (commit_mask_o)
  );

endmodule

/* source/hsv_core_commit.sv */
`timescale 1ns/1ps

module hsv_core_commit
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,

  input  logic         flush_req_i,
  output logic         flush_ack_o,

  input  commit_data_t alu_data_i,
  input  logic         alu_valid_i,
  input  commit_data_t branch_data_i,
  input  logic         branch_valid_i,
  output logic         alu_ready_o,
  output logic         branch_ready_o,

  output logic         alu_commit_o,
  output logic         branch_commit_o,
  output logic         commit_o,
  input  logic         begin_irq_i,

  output logic         flush_begin_o,
  output logic         trap_o,
  output logic [4:0]   trap_cause_o,
  output word          trap_value_o,
  output word          next_pc_o,

  output reg_addr      wr_addr_o,
  output word          wr_data_o,
  output logic         wr_en_o,

  output reg_mask      commit_mask_o
);

  insn_token    token_q;
  logic         alu_committable;
  logic         branch_committable;
  logic         token_enable;
  logic         token_clear;
  commit_data_t used_data;

  // A lane may hand over only the instruction whose turn it is
  assign alu_ready_o    = token_q == alu_data_i.token;
  assign branch_ready_o = token_q == branch_data_i.token;

  assign alu_committable    = alu_ready_o & alu_valid_i;
  assign branch_committable = branch_ready_o & branch_valid_i;

  assign alu_commit_o    = alu_committable & !alu_data_i.trap;
  assign branch_commit_o = branch_committable & !branch_data_i.trap;
  assign commit_o        = alu_commit_o | branch_commit_o;

  always_comb begin
    if (alu_committable) used_data = alu_data_i;
    else if (branch_committable) used_data = branch_data_i;
    else used_data = '0;
  end

  assign flush_begin_o = used_data.jump | used_data.trap;

  assign wr_addr_o     = used_data.rd_addr;
  assign wr_data_o     = used_data.result;
  assign wr_en_o       = used_data.writeback & !used_data.trap;
  assign commit_mask_o = used_data.trap ? '0 : used_data.rd_mask;

  // Trap leaves the token stuck until flush
  assign token_enable = commit_o & !begin_irq_i;
  assign token_clear  = flush_ack_o & !flush_req_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      token_q      <= '0;
      flush_ack_o  <= 1'b0;
      trap_o       <= 1'b0;
      trap_cause_o <= '0;
      trap_value_o <= '0;
      next_pc_o    <= '0;
    end else begin
      flush_ack_o <= flush_req_i;
      if (token_clear) token_q <= '0;
      else if (token_enable) token_q <= token_q + 1'b1;

      trap_o <= used_data.trap;
      if (used_data.trap) begin
        trap_cause_o <= used_data.trap_cause;
        trap_value_o <= used_data.trap_value;
      end

      if (commit_o) next_pc_o <= used_data.next_pc;
    end
  end

endmodule

/* source/hsv_core_pkg.sv */
package hsv_core_pkg;

  typedef logic [31:0] word;
  typedef logic [4:0]  reg_addr;

  // Issue order tag, wraps
  typedef logic [2:0]  insn_token;

  // One bit per architectural register
  typedef logic [31:0] reg_mask;

  // What a lane offers to commit
  typedef struct packed {
    insn_token  token;
    reg_addr    rd_addr;
    word        result;
    logic       writeback;
    logic       jump;
    logic       trap;
    logic [4:0] trap_cause;
    word        trap_value;
    word        next_pc;
    reg_mask    rd_mask;
  } commit_data_t;

  // Entries per lane queue
  localparam int UNIT_DEPTH = 2;

endpackage

/* source/hsv_isa_pkg.sv */
package hsv_isa_pkg;

  // Register-register arithmetic layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // Conditional branch layout, immediate scattered
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_view_t;

  typedef union packed {
    r_view_t r_view;
    b_view_t b_view;
  } insn_word_u;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  localparam logic [4:0] CAUSE_MISALIGNED_FETCH = 5'd0;
  localparam logic [4:0] CAUSE_ILLEGAL_INSN     = 5'd2;

endpackage
